// File: src/eu_pkg.sv
package eu_pkg;

    // datapath widths
    localparam int DATA_W = 16;
    localparam int ADDR_W = 20;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [7:0]        byte_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // word registers are AW CW DW BW SP BP IX IY (0 to 7)
    // byte registers 0-3 are the low halves of AW..BW, 4-7 the high halves
    typedef logic [2:0] reg_id_t;

    // registers named by the 16-bit addressing modes
    localparam reg_id_t REG_BW = 3'd3;
    localparam reg_id_t REG_BP = 3'd5;
    localparam reg_id_t REG_IX = 3'd6;
    localparam reg_id_t REG_IY = 3'd7;

    // bus command, held until the done pulse
    typedef enum logic [1:0]
    {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_cmd_t;

    // segment choice for a memory operand
    typedef enum logic [1:0]
    {
        SEG_ES = 2'd0,
        SEG_CS = 2'd1,
        SEG_SS = 2'd2,
        SEG_DS = 2'd3
    } seg_sel_t;

    // move forms recognised by the decoder
    typedef enum logic [2:0]
    {
        MOV_NONE         = 3'd0,
        MOV_RM_FROM_R    = 3'd1,
        MOV_R_FROM_RM    = 3'd2,
        MOV_REG_FROM_IMM = 3'd3,
        MOV_RM_FROM_IMM  = 3'd4
    } mov_form_t;

endpackage

// File: src/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch
(
    input  logic          clk,
    input  logic          reset,
    input  eu_pkg::byte_t prefetch_data,
    input  logic          queue_empty,
    input  logic          need_modrm,
    input  logic          need_disp,
    input  logic          disp_word,
    input  logic          need_imm,
    input  logic          imm_word,
    input  logic          finish,
    output logic          queue_pop,
    output logic          start,
    output eu_pkg::byte_t opcode,
    output eu_pkg::byte_t modrm,
    output eu_pkg::word_t disp,
    output eu_pkg::word_t imm
);
    import eu_pkg::*;

    typedef enum logic [2:0]
    {
        ST_OPCODE,
        ST_MODRM,
        ST_DISP_LO,
        ST_DISP_HI,
        ST_IMM_LO,
        ST_IMM_HI,
        ST_EXEC
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;
    fetch_state_t after_disp;
    byte_t        opcode_q;
    byte_t        modrm_q;
    logic         run;
    logic         take;

    // the decoder looks at the byte being taken, so the next state is known now
    assign opcode = (state == ST_OPCODE) ? prefetch_data : opcode_q;
    assign modrm  = (state == ST_MODRM) ? prefetch_data : modrm_q;

    // one byte per cycle while fetching and the queue has data
    assign take      = run && (state != ST_EXEC) && !queue_empty;
    assign queue_pop = take;

    assign after_disp = need_imm ? ST_IMM_LO : ST_EXEC;

    always_comb
    begin
        next_state = state;
        if (state == ST_EXEC)
        begin
            if (finish)
                next_state = ST_OPCODE;
        end
        else if (take)
        begin
            case (state)
                ST_OPCODE:  next_state = need_modrm ? ST_MODRM : after_disp;
                ST_MODRM:   next_state = need_disp ? ST_DISP_LO : after_disp;
                ST_DISP_LO: next_state = disp_word ? ST_DISP_HI : after_disp;
                ST_DISP_HI: next_state = after_disp;
                ST_IMM_LO:  next_state = imm_word ? ST_IMM_HI : ST_EXEC;
                default:    next_state = ST_EXEC;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_OPCODE;
            run   <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            // fetch begins the cycle after reset is released
            run   <= 1'b1;
            state <= next_state;
            // start strobes for the first execute cycle only
            start <= (state != ST_EXEC) && (next_state == ST_EXEC);
        end
    end

    // instruction bytes land in the register of the current state
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            case (state)
                ST_OPCODE:  opcode_q   <= prefetch_data;
                ST_MODRM:   modrm_q    <= prefetch_data;
                ST_DISP_LO: disp[7:0]  <= prefetch_data;
                ST_DISP_HI: disp[15:8] <= prefetch_data;
                ST_IMM_LO:  imm[7:0]   <= prefetch_data;
                ST_IMM_HI:  imm[15:8]  <= prefetch_data;
                default:    ;
            endcase
        end
    end

    // never pop an empty queue
    assert property (@(posedge clk) disable iff (reset) queue_pop |-> !queue_empty);

endmodule

// File: src/mov_decoder.sv
`timescale 1ns/1ps

module mov_decoder
(
    input  eu_pkg::byte_t     opcode,
    input  eu_pkg::byte_t     modrm,
    output logic              need_modrm,
    output logic              need_disp,
    output logic              disp_word,
    output logic              need_imm,
    output logic              imm_word,
    output eu_pkg::mov_form_t form,
    output logic              word_op,
    output eu_pkg::reg_id_t   reg_field,
    output logic              rm_is_reg,
    output eu_pkg::reg_id_t   rm_reg,
    output eu_pkg::reg_id_t   base_sel,
    output eu_pkg::reg_id_t   index_sel,
    output logic              use_base,
    output logic              use_index,
    output eu_pkg::seg_sel_t  seg
);
    import eu_pkg::*;

    logic [1:0] mode;
    reg_id_t    rm;
    logic       direct;

    assign mode   = modrm[7:6];
    assign rm     = modrm[2:0];
    // mod 00 rm 110 is a bare 16-bit address
    assign direct = (mode == 2'b00) && (rm == 3'd6);

    always_comb
    begin
        need_modrm = 1'b0;
        need_imm   = 1'b0;
        imm_word   = 1'b0;
        form       = MOV_NONE;
        word_op    = 1'b0;
        reg_field  = modrm[5:3];
        casez (opcode)
            // 88/89 store reg, 8A/8B load reg; bit 1 is direction, bit 0 size
            8'b1000_10??:
            begin
                need_modrm = 1'b1;
                form       = opcode[1] ? MOV_R_FROM_RM : MOV_RM_FROM_R;
                word_op    = opcode[0];
            end
            // B0-BF, register and size sit in the opcode
            8'b1011_????:
            begin
                need_imm  = 1'b1;
                imm_word  = opcode[3];
                form      = MOV_REG_FROM_IMM;
                word_op   = opcode[3];
                reg_field = opcode[2:0];
            end
            // C6/C7 immediate to rm
            8'b1100_011?:
            begin
                need_modrm = 1'b1;
                need_imm   = 1'b1;
                imm_word   = opcode[0];
                form       = MOV_RM_FROM_IMM;
                word_op    = opcode[0];
            end
            // anything else is a one byte no-op
            default: ;
        endcase
    end

    assign need_disp = need_modrm && ((mode == 2'b01) || (mode == 2'b10) || direct);
    assign disp_word = (mode == 2'b10) || direct;
    assign rm_is_reg = (mode == 2'b11);
    assign rm_reg    = rm;

    // rm 0-3 pair a base with an index, 4-5 index only, 6-7 base only
    assign use_index = (rm < 3'd6);
    assign index_sel = rm[0] ? REG_IY : REG_IX;
    assign use_base  = (rm != 3'd4) && (rm != 3'd5) && !direct;
    assign base_sel  = ((rm == 3'd2) || (rm == 3'd3) || (rm == 3'd6)) ? REG_BP : REG_BW;

    // BP-based modes default to the stack segment
    assign seg = (use_base && (base_sel == REG_BP)) ? SEG_SS : SEG_DS;

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file
(
    input  logic            clk,
    input  logic            reset,
    input  logic            write_enable,
    input  eu_pkg::reg_id_t write_id,
    input  logic            write_word,
    input  eu_pkg::word_t   write_data,
    input  eu_pkg::reg_id_t read_id,
    input  logic            read_word,
    input  eu_pkg::reg_id_t base_sel,
    input  eu_pkg::reg_id_t index_sel,
    output eu_pkg::word_t   read_data,
    output eu_pkg::word_t   base_data,
    output eu_pkg::word_t   index_data
);
    import eu_pkg::*;

    word_t   regs [0:7];
    reg_id_t read_pair;
    reg_id_t write_pair;
    byte_t   read_byte;

    // byte codes map onto the first four words
    assign read_pair  = {1'b0, read_id[1:0]};
    assign write_pair = {1'b0, write_id[1:0]};

    // bit 2 of a byte code picks the high half
    assign read_byte = read_id[2] ? regs[read_pair][15:8] : regs[read_pair][7:0];
    assign read_data = read_word ? regs[read_id] : {8'h00, read_byte};

    // address ports for the effective address
    assign base_data  = regs[base_sel];
    assign index_data = regs[index_sel];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (write_enable)
        begin
            if (write_word)
                regs[write_id] <= write_data;
            // byte writes leave the other half alone
            else if (write_id[2])
                regs[write_pair][15:8] <= write_data[7:0];
            else
                regs[write_pair][7:0] <= write_data[7:0];
        end
    end

endmodule

// File: src/address_generator.sv
`timescale 1ns/1ps

module address_generator
(
    input  eu_pkg::seg_sel_t seg,
    input  eu_pkg::word_t    es,
    input  eu_pkg::word_t    cs,
    input  eu_pkg::word_t    ss,
    input  eu_pkg::word_t    ds,
    input  eu_pkg::word_t    base_data,
    input  eu_pkg::word_t    index_data,
    input  logic             use_base,
    input  logic             use_index,
    input  eu_pkg::word_t    disp,
    input  logic             disp_word,
    input  logic             need_disp,
    output eu_pkg::addr_t    physical
);
    import eu_pkg::*;

    word_t seg_base;
    word_t disp_ext;
    word_t offset;

    always_comb
    begin
        case (seg)
            SEG_ES:  seg_base = es;
            SEG_CS:  seg_base = cs;
            SEG_SS:  seg_base = ss;
            default: seg_base = ds;
        endcase
    end

    // 8-bit displacement is signed
    assign disp_ext = !need_disp ? '0 : disp_word ? disp : {{8{disp[7]}}, disp[7:0]};

    // effective address wraps inside the 64K segment
    assign offset = (use_base ? base_data : '0) + (use_index ? index_data : '0) + disp_ext;

    // segment * 16 + offset, carry past bit 19 is dropped
    assign physical = {seg_base, 4'h0} + {4'h0, offset};

endmodule

// File: src/mov_executor.sv
`timescale 1ns/1ps

module mov_executor
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  eu_pkg::mov_form_t form,
    input  logic              word_op,
    input  eu_pkg::reg_id_t   reg_field,
    input  logic              rm_is_reg,
    input  eu_pkg::reg_id_t   rm_reg,
    input  eu_pkg::word_t     imm,
    input  eu_pkg::word_t     read_data,
    input  eu_pkg::addr_t     physical,
    input  eu_pkg::word_t     data_in,
    input  logic              bus_command_done,
    output logic              finish,
    output eu_pkg::reg_id_t   read_id,
    output logic              read_word,
    output logic              write_enable,
    output eu_pkg::reg_id_t   write_id,
    output logic              write_word,
    output eu_pkg::word_t     write_data,
    output eu_pkg::bus_cmd_t  bus_command,
    output eu_pkg::addr_t     bus_address,
    output logic              bus_word,
    output eu_pkg::word_t     data_out
);
    import eu_pkg::*;

    logic mem_access;
    logic busy;
    logic bus_end;
    logic to_reg_field;

    // rm forms with mod != 11 go to memory
    assign mem_access = !rm_is_reg && ((form == MOV_RM_FROM_R) || (form == MOV_R_FROM_RM)
                        || (form == MOV_RM_FROM_IMM));
    assign busy    = (bus_command != BUS_IDLE);
    assign bus_end = busy && bus_command_done;

    // register moves and no-ops end in the start cycle, memory moves on done
    assign finish = (start && !mem_access) || bus_end;

    // the register source is reg for a store, rm for a register load
    assign read_id   = (form == MOV_RM_FROM_R) ? reg_field : rm_reg;
    assign read_word = word_op;

    assign to_reg_field = (form == MOV_R_FROM_RM) || (form == MOV_REG_FROM_IMM);
    assign write_id     = to_reg_field ? reg_field : rm_reg;
    assign write_word   = word_op;

    // register moves write at the start edge, memory loads at the done edge
    assign write_enable = (start && !mem_access && (form != MOV_NONE))
                          || (bus_end && (bus_command == BUS_READ));

    always_comb
    begin
        case (form)
            MOV_REG_FROM_IMM,
            MOV_RM_FROM_IMM: write_data = imm;
            MOV_R_FROM_RM:   write_data = rm_is_reg ? read_data : data_in;
            default:         write_data = read_data;
        endcase
    end

    // command issued on the edge after start, dropped on the edge after done
    always_ff @(posedge clk)
    begin
        if (reset)
            bus_command <= BUS_IDLE;
        else if (start && mem_access)
            bus_command <= (form == MOV_R_FROM_RM) ? BUS_READ : BUS_WRITE;
        else if (bus_end)
            bus_command <= BUS_IDLE;
    end

    // address, size and store data captured with the command
    always_ff @(posedge clk)
    begin
        if (start && mem_access)
        begin
            bus_address <= physical;
            bus_word    <= word_op;
            // byte stores use the low lane, read_data is already zero-extended
            data_out    <= (form == MOV_RM_FROM_IMM) ? imm : read_data;
        end
    end

    // command and address held steady until done
    assert property (@(posedge clk) disable iff (reset)
        (busy && !bus_command_done) |=> ($stable(bus_command) && $stable(bus_address)));

endmodule

// File: src/execution_unit.sv
`timescale 1ns/1ps

module execution_unit
(
    input  logic             clk,
    input  logic             reset,
    input  eu_pkg::byte_t    prefetch_data,
    input  logic             queue_empty,
    input  eu_pkg::word_t    es,
    input  eu_pkg::word_t    cs,
    input  eu_pkg::word_t    ss,
    input  eu_pkg::word_t    ds,
    input  eu_pkg::word_t    data_in,
    input  logic             bus_command_done,
    output logic             queue_pop,
    output logic             instruction_done,
    output eu_pkg::bus_cmd_t bus_command,
    output eu_pkg::addr_t    bus_address,
    output logic             bus_word,
    output eu_pkg::word_t    data_out
);
    import eu_pkg::*;

    // fetch to decode
    byte_t     opcode;
    byte_t     modrm;
    word_t     disp;
    word_t     imm;
    logic      need_modrm;
    logic      need_disp;
    logic      disp_word;
    logic      need_imm;
    logic      imm_word;

    // decoded move
    mov_form_t form;
    logic      word_op;
    reg_id_t   reg_field;
    logic      rm_is_reg;
    reg_id_t   rm_reg;

    // addressing
    reg_id_t   base_sel;
    reg_id_t   index_sel;
    logic      use_base;
    logic      use_index;
    seg_sel_t  seg;
    word_t     base_data;
    word_t     index_data;
    addr_t     physical;

    // executor and register file
    logic      start;
    logic      finish;
    reg_id_t   read_id;
    logic      read_word;
    word_t     read_data;
    logic      write_enable;
    reg_id_t   write_id;
    logic      write_word;
    word_t     write_data;

    // every instruction ends with exactly one finish strobe
    assign instruction_done = finish;

    operand_fetch fetch_inst (.*);

    mov_decoder decode_inst (.*);

    register_file regfile_inst (.*);

    address_generator agen_inst (.*);

    mov_executor exec_inst (.*);

endmodule

// File: sim/tb_execution_unit.sv
`timescale 1ns/1ps

module tb_execution_unit;
    import eu_pkg::*;

    // instruction kinds, numbered like the tests that focus on them
    localparam int K_IMM    = 0;
    localparam int K_RR     = 1;
    localparam int K_LOAD   = 2;
    localparam int K_STORE  = 3;
    localparam int K_IMM_RM = 4;
    localparam int K_NOP    = 5;

    localparam int NUM_TESTS   = 6;
    localparam int BODY_LEN    = 40;
    // eight register dump stores close every program
    localparam int TEST_LEN    = BODY_LEN + 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_LEN * 16 + 100;

    logic     clk;
    logic     reset;
    byte_t    prefetch_data;
    logic     queue_empty;
    word_t    es;
    word_t    cs;
    word_t    ss;
    word_t    ds;
    word_t    data_in;
    logic     bus_command_done;
    logic     queue_pop;
    logic     instruction_done;
    bus_cmd_t bus_command;
    addr_t    bus_address;
    logic     bus_word;
    word_t    data_out;

    integer   seed;
    int       errors;
    int       checks;
    int       test_errors;
    int       tests_failed;
    int       cycles;
    int       n_instr;
    string    cur_test;

    // reference state
    word_t    mregs [0:7];
    byte_t    mmem [addr_t];
    // memory seen by the bus responder
    byte_t    emem [addr_t];

    // program bytes and the bus commands it should produce
    byte_t    prog [$];
    bus_cmd_t exp_cmd [$];
    addr_t    exp_addr [$];
    logic     exp_word [$];
    word_t    exp_data [$];

    execution_unit DUT
    (
        .clk              (clk),
        .reset            (reset),
        .prefetch_data    (prefetch_data),
        .queue_empty      (queue_empty),
        .es               (es),
        .cs               (cs),
        .ss               (ss),
        .ds               (ds),
        .data_in          (data_in),
        .bus_command_done (bus_command_done),
        .queue_pop        (queue_pop),
        .instruction_done (instruction_done),
        .bus_command      (bus_command),
        .bus_address      (bus_address),
        .bus_word         (bus_word),
        .data_out         (data_out)
    );

    always #2 clk = ~clk;

    // watchdog sized from the total instruction count
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: instructions did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "imm_loads";
            1:       return "reg_moves";
            2:       return "mem_loads";
            3:       return "addr_modes";
            4:       return "imm_to_rm";
            default: return "mixed_gaps";
        endcase
    endfunction

    // unmapped bytes, every address bit takes part
    function automatic byte_t fill_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ {a[3:0], a[19:16]};
    endfunction

    function automatic byte_t model_rd(input addr_t a);
        return mmem.exists(a) ? mmem[a] : fill_byte(a);
    endfunction

    function automatic byte_t env_rd(input addr_t a);
        return emem.exists(a) ? emem[a] : fill_byte(a);
    endfunction

    // little endian, the second byte address wraps at 2^20
    function automatic word_t model_load(input addr_t a, input logic w);
        addr_t a1;
        a1 = a + 20'd1;
        return w ? {model_rd(a1), model_rd(a)} : {8'h00, model_rd(a)};
    endfunction

    task automatic model_store(input addr_t a, input logic w, input word_t d);
        addr_t a1;
        a1 = a + 20'd1;
        mmem[a] = d[7:0];
        if (w)
            mmem[a1] = d[15:8];
    endtask

    // byte codes 0-3 low halves, 4-7 high halves of AW..BW
    function automatic word_t reg_get(input reg_id_t id, input logic w);
        if (w)
            return mregs[id];
        if (id[2])
            return {8'h00, mregs[id[1:0]][15:8]};
        return {8'h00, mregs[id[1:0]][7:0]};
    endfunction

    task automatic reg_set(input reg_id_t id, input logic w, input word_t v);
        if (w)
            mregs[id] = v;
        else if (id[2])
            mregs[id[1:0]][15:8] = v[7:0];
        else
            mregs[id[1:0]][7:0] = v[7:0];
    endtask

    // 8086 effective address: BW=3 BP=5 IX=6 IY=7, BP modes use SS
    function automatic addr_t model_addr(input logic [1:0] mode, input logic [2:0] rm,
                                         input word_t d);
        word_t off;
        word_t seg_val;
        word_t dx;
        dx = (mode == 2'd1) ? {{8{d[7]}}, d[7:0]} : (mode == 2'd2) ? d : 16'h0000;
        seg_val = ds;
        case (rm)
            3'd0: off = mregs[3] + mregs[6];
            3'd1: off = mregs[3] + mregs[7];
            3'd2:
            begin
                off = mregs[5] + mregs[6];
                seg_val = ss;
            end
            3'd3:
            begin
                off = mregs[5] + mregs[7];
                seg_val = ss;
            end
            3'd4: off = mregs[6];
            3'd5: off = mregs[7];
            3'd6:
            begin
                if (mode == 2'd0)
                    off = d;
                else
                begin
                    off = mregs[5];
                    seg_val = ss;
                end
            end
            default: off = mregs[3];
        endcase
        off = off + dx;
        return {seg_val, 4'h0} + {4'h0, off};
    endfunction

    // modrm byte plus whatever displacement the mode carries
    task automatic emit_modrm(input logic [1:0] mode, input logic [2:0] regf,
                              input logic [2:0] rm, output addr_t a);
        word_t d;
        d = $random(seed);
        prog.push_back({mode, regf, rm});
        if (mode == 2'd1)
            prog.push_back(d[7:0]);
        else if ((mode == 2'd2) || ((mode == 2'd0) && (rm == 3'd6)))
        begin
            prog.push_back(d[7:0]);
            prog.push_back(d[15:8]);
        end
        a = model_addr(mode, rm, d);
    endtask

    task automatic expect_bus(input bus_cmd_t c, input addr_t a, input logic w, input word_t d);
        exp_cmd.push_back(c);
        exp_addr.push_back(a);
        exp_word.push_back(w);
        exp_data.push_back(d);
    endtask

    task automatic gen_instr(input int kind);
        logic       w;
        reg_id_t    r;
        reg_id_t    m;
        logic [1:0] mode;
        word_t      v;
        word_t      imm;
        byte_t      op;
        addr_t      a;
        w    = (rnd(2) == 1);
        r    = reg_id_t'(rnd(8));
        m    = reg_id_t'(rnd(8));
        mode = 2'(rnd(3));
        imm  = $random(seed);
        case (kind)
            K_IMM:
            begin
                prog.push_back({4'hB, w, r});
                prog.push_back(imm[7:0]);
                if (w)
                    prog.push_back(imm[15:8]);
                reg_set(r, w, imm);
            end
            K_RR:
            begin
                prog.push_back({7'b1000101, w});
                prog.push_back({2'b11, r, m});
                reg_set(r, w, reg_get(m, w));
            end
            K_LOAD:
            begin
                prog.push_back({7'b1000101, w});
                emit_modrm(mode, r, m, a);
                v = model_load(a, w);
                expect_bus(BUS_READ, a, w, v);
                reg_set(r, w, v);
            end
            K_STORE:
            begin
                prog.push_back({7'b1000100, w});
                emit_modrm(mode, r, m, a);
                v = reg_get(r, w);
                expect_bus(BUS_WRITE, a, w, v);
                model_store(a, w, v);
            end
            K_IMM_RM:
            begin
                mode = 2'(rnd(4));
                prog.push_back({7'b1100011, w});
                emit_modrm(mode, 3'd0, m, a);
                prog.push_back(imm[7:0]);
                if (w)
                    prog.push_back(imm[15:8]);
                if (mode == 2'b11)
                    reg_set(m, w, imm);
                else
                begin
                    expect_bus(BUS_WRITE, a, w, imm);
                    model_store(a, w, imm);
                end
            end
            default:
            begin
                op = byte_t'(rnd(256));
                // keep clear of the MOV opcodes
                if ((op[7:2] == 6'b100010) || (op[7:4] == 4'hB) || (op[7:1] == 7'b1100011))
                    op = 8'h90;
                prog.push_back(op);
            end
        endcase
        n_instr++;
    endtask

    // word stores of every register to direct addresses
    task automatic gen_dump;
        addr_t a;
        for (int r = 0; r < 8; r++)
        begin
            prog.push_back(8'h89);
            emit_modrm(2'b00, 3'(r), 3'd6, a);
            expect_bus(BUS_WRITE, a, 1'b1, mregs[r]);
            model_store(a, 1'b1, mregs[r]);
            n_instr++;
        end
    endtask

    // compare a new bus command against the next expected one
    task automatic check_command;
        word_t d;
        if (exp_cmd.size() == 0)
        begin
            $display("%s: bus command issued with no instruction expecting one", cur_test);
            errors++;
            test_errors++;
            return;
        end
        d = exp_data[0];
        check("bus command", exp_cmd[0], bus_command);
        check("bus address", exp_addr[0], bus_address);
        check("bus word", exp_word[0], bus_word);
        if (exp_cmd[0] == BUS_WRITE)
        begin
            if (exp_word[0])
                check("store data", d, data_out);
            else
                check("store data", {8'h00, d[7:0]}, {8'h00, data_out[7:0]});
        end
        void'(exp_cmd.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_word.pop_front());
        void'(exp_data.pop_front());
    endtask

    task automatic run_test(input int t);
        int    kind;
        int    gap_pct;
        int    ptr;
        int    done_count;
        int    wait_cnt;
        int    tail;
        logic  in_txn;
        addr_t a1;
        cur_test = test_name(t);
        prog.delete();
        exp_cmd.delete();
        exp_addr.delete();
        exp_word.delete();
        exp_data.delete();
        n_instr     = 0;
        test_errors = 0;
        for (int i = 0; i < BODY_LEN; i++)
        begin
            if (t == 5)
                kind = rnd(6);
            else if (rnd(2) == 1)
                kind = t;
            else
                kind = (rnd(2) == 1) ? K_IMM : K_STORE;
            gen_instr(kind);
        end
        gen_dump();
        gap_pct    = (t == 5) ? 40 : 15;
        ptr        = 0;
        done_count = 0;
        wait_cnt   = 0;
        tail       = 0;
        in_txn     = 1'b0;
        // a few idle cycles after the last instruction catch extra done pulses
        while ((done_count < n_instr) || (tail < 4))
        begin
            if (done_count >= n_instr)
                tail++;
            if ((ptr < prog.size()) && (rnd(100) >= gap_pct))
            begin
                queue_empty   = 1'b0;
                prefetch_data = prog[ptr];
            end
            else
            begin
                queue_empty   = 1'b1;
                prefetch_data = $random(seed);
            end
            bus_command_done = 1'b0;
            data_in          = $random(seed);
            if (in_txn)
            begin
                if (wait_cnt == 0)
                begin
                    a1 = bus_address + 20'd1;
                    bus_command_done = 1'b1;
                    data_in = {env_rd(a1), env_rd(bus_address)};
                end
                else
                    wait_cnt--;
            end
            @(negedge clk);
            if (queue_pop && queue_empty)
            begin
                $display("%s: queue popped while empty", cur_test);
                errors++;
                test_errors++;
            end
            else if (queue_pop)
                ptr++;
            if (instruction_done)
                done_count++;
            if (bus_command_done)
            begin
                // write lands in memory at the done edge
                if (bus_command == BUS_WRITE)
                begin
                    a1 = bus_address + 20'd1;
                    emem[bus_address] = data_out[7:0];
                    if (bus_word)
                        emem[a1] = data_out[15:8];
                end
                in_txn = 1'b0;
            end
            else if ((bus_command != BUS_IDLE) && !in_txn)
            begin
                check_command();
                in_txn   = 1'b1;
                wait_cnt = rnd(3);
            end
            @(posedge clk);
            #1;
        end
        check("instruction count", n_instr, done_count);
        check("bytes consumed", prog.size(), ptr);
        check("pending bus commands", 0, exp_cmd.size());
        if (test_errors != 0)
            tests_failed++;
        $display("test %s finished: %0d instructions, %0d errors", cur_test, n_instr,
                 test_errors);
    endtask

    initial
    begin
        addr_t a;
        byte_t b;
        seed             = 29;
        errors           = 0;
        checks           = 0;
        tests_failed     = 0;
        cycles           = 0;
        clk              = 1'b0;
        reset            = 1'b1;
        prefetch_data    = 8'h00;
        queue_empty      = 1'b1;
        data_in          = 16'h0000;
        bus_command_done = 1'b0;
        es = $random(seed);
        cs = $random(seed);
        ds = $random(seed);
        ss = $random(seed);
        if (ss == ds)
            ss = ds + 16'h0101;
        for (int i = 0; i < 8; i++)
            mregs[i] = 16'h0000;
        // sparse random memory image shared by model and responder
        for (int i = 0; i < 64; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            mmem[a] = b;
            emem[a] = b;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, tests_failed,
                 checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: execution_unit.f
src/eu_pkg.sv
src/operand_fetch.sv
src/mov_decoder.sv
src/register_file.sv
src/address_generator.sv
src/mov_executor.sv
src/execution_unit.sv
sim/tb_execution_unit.sv
